// ==== consolePkg.sv ====
`default_nettype none

package consolePkg;

    // one character as held in the text RAM
    typedef logic [7:0] CharCode_t;

    // bit 7 is the leftmost pixel
    typedef logic [7:0] GlyphLine_t;

    typedef logic [2:0] LineIndex_t;
    typedef logic [2:0] RowIndex_t;
    typedef logic [3:0] ColIndex_t;

    // row * columns + column
    typedef logic [6:0] CellAddress_t;

    typedef enum logic [2:0] {
        ground,
        escape,
        csi,
        csiTwo,
        clearing
    } ParserState_t;

    // rows and columns are powers of two, so the modulo only drops high bits
    function automatic CellAddress_t cellAddress(input RowIndex_t row, input ColIndex_t col,
                                                 input int rows, input int columns);
        return CellAddress_t'((int'(row) % rows) * columns + (int'(col) % columns));
    endfunction

endpackage

`default_nettype wire

// ==== fontRom.sv ====
`timescale 1ns/1ps
`default_nettype none

module fontRom
    import consolePkg::*;
(
    input  wire        clk,
    input  wire        [7:0] fontCode,
    input  wire        [2:0] fontLine,
    output GlyphLine_t fontBits
);

    // synthetic glyphs, line L of code C is C rotated left by L
    function automatic GlyphLine_t glyphLine(input CharCode_t code, input LineIndex_t line);
        GlyphLine_t bits;
        case (line)
            3'd0: bits = code;
            3'd1: bits = {code[6:0], code[7]};
            3'd2: bits = {code[5:0], code[7:6]};
            3'd3: bits = {code[4:0], code[7:5]};
            3'd4: bits = {code[3:0], code[7:4]};
            3'd5: bits = {code[2:0], code[7:3]};
            3'd6: bits = {code[1:0], code[7:2]};
            3'd7: bits = {code[0], code[7:1]};
        endcase
        return bits;
    endfunction

    // registered like a block ROM
    always_ff @(posedge clk) begin
        fontBits <= glyphLine(fontCode, fontLine);
    end

endmodule

`default_nettype wire

// ==== glyphRenderer.sv ====
`timescale 1ns/1ps
`default_nettype none

module glyphRenderer
    import consolePkg::*;
#(
    parameter int Rows    = 8,
    parameter int Columns = 16
) (
    input  wire          clk,
    input  wire          reset,
    // external cell-read port, four-phase
    input  wire          readReq,
    input  wire          [2:0] readRow,
    input  wire          [3:0] readCol,
    input  wire          [2:0] readLine,
    output logic         readAck,
    output GlyphLine_t   glyphBits,
    // cursor from the parser
    input  wire          [2:0] cursorRow,
    input  wire          [3:0] cursorCol,
    // text RAM port B
    output CellAddress_t readAddress,
    input  wire          [7:0] readData,
    // font ROM
    output CharCode_t    fontCode,
    output LineIndex_t   fontLine,
    input  wire          [7:0] fontBits
);

    typedef enum logic [2:0] {
        idle,
        fetchChar,
        fetchGlyph,
        capture,
        holdAck,
        dropAck
    } RenderState_t;

    RenderState_t state;
    logic         cursorHit;

    // request inputs stay stable until readAck falls
    assign cursorHit = (readRow == cursorRow) && (readCol == cursorCol);

    // character goes straight from the RAM output to the ROM address
    assign fontCode = readData;

    always_ff @(posedge clk) begin
        if (reset) begin
            state   <= idle;
            readAck <= 1'b0;
        end else begin
            case (state)
                idle: begin
                    if (readReq) begin
                        state <= fetchChar;
                    end
                end
                // RAM read in flight
                fetchChar:  state <= fetchGlyph;
                // ROM read in flight
                fetchGlyph: state <= capture;
                capture: begin
                    readAck <= 1'b1;
                    state   <= holdAck;
                end
                holdAck: begin
                    if (!readReq) begin
                        state <= dropAck;
                    end
                end
                dropAck: begin
                    readAck <= 1'b0;
                    state   <= idle;
                end
                default: state <= idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == idle && readReq) begin
            readAddress <= cellAddress(readRow, readCol, Rows, Columns);
            fontLine    <= readLine;
        end
        // inverse video on the cursor cell
        if (state == capture) begin
            glyphBits <= fontBits ^ {8{cursorHit}};
        end
    end

endmodule

`default_nettype wire

// ==== runSim.sh ====
#!/bin/sh
# builds and runs the virtualConsole testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module tbVirtualConsole -f virtualConsole.f \
    --Mdir obj_dir -o simVirtualConsole
if [ $? -ne 0 ]; then
    echo "compile failed"
    exit 1
fi

output=$(./obj_dir/simVirtualConsole)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -q "^Verification passed$"; then
    exit 0
fi
echo "pass message not found in simulation output"
exit 1

// ==== tbVirtualConsole.sv ====
`timescale 1ns/1ps
`default_nettype none

module tbVirtualConsole;

    localparam int ClksPerBit = 16;
    localparam int Rows       = 8;
    localparam int Columns    = 16;
    localparam int Cells      = Rows * Columns;
    // roughly twice the cycles that all tests take together
    localparam int TimeoutCycles = 40000;

    localparam int ModelGround = 0;
    localparam int ModelEscape = 1;
    localparam int ModelCsi    = 2;
    localparam int ModelCsiTwo = 3;

    logic       clk = 1'b0;
    logic       reset;
    logic       uartRx;
    logic       readReq;
    logic [2:0] readRow;
    logic [3:0] readCol;
    logic [2:0] readLine;
    logic       readAck;
    logic [7:0] glyphBits;

    // reference screen and cursor
    logic [7:0]  modelScreen [Cells];
    int          modelRow;
    int          modelCol;
    int          modelState;
    logic [31:0] rngState;
    int          cycleCount;

    // handshake monitor history
    logic       prevReq;
    logic       prevAck;
    logic [7:0] prevGlyph;

    virtualConsole #(
        .ClksPerBit(ClksPerBit),
        .Rows(Rows),
        .Columns(Columns)
    ) dut (
        .clk(clk),
        .reset(reset),
        .uartRx(uartRx),
        .readReq(readReq),
        .readRow(readRow),
        .readCol(readCol),
        .readLine(readLine),
        .readAck(readAck),
        .glyphBits(glyphBits)
    );

    always #10 clk = ~clk;

    task automatic stopOnError();
        $display("Verification failed");
        $fatal(1, "simulation stopped at the first error");
    endtask

    always @(posedge clk) begin
        cycleCount = cycleCount + 1;
        if (cycleCount > TimeoutCycles) begin
            $display("timeout: the tests did not finish within %0d cycles", TimeoutCycles);
            stopOnError();
        end
    end

    // handshake rules sampled mid-cycle
    always @(negedge clk) begin
        if (reset) begin
            assert (!readAck) else begin
                $display("[FAIL] handshake reset: expected readAck 0, actual %0b", readAck);
                stopOnError();
            end
        end else begin
            if (readAck && !prevAck) begin
                assert (prevReq && readReq) else begin
                    $display("readAck rose while readReq was low");
                    stopOnError();
                end
            end
            if (readAck && prevAck) begin
                assert (glyphBits == prevGlyph) else begin
                    $display("[FAIL] handshake hold: expected glyphBits %02h, actual %02h",
                             prevGlyph, glyphBits);
                    stopOnError();
                end
            end
            if (!readAck && prevAck) begin
                assert (!prevReq) else begin
                    $display("readAck fell while readReq was still high");
                    stopOnError();
                end
            end
        end
        prevReq   <= readReq;
        prevAck   <= readAck;
        prevGlyph <= glyphBits;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic nextRandom(output logic [31:0] value);
        rngState = xorshift(rngState);
        value = rngState;
    endtask

    task automatic clearModel();
        for (int i = 0; i < Cells; i++) begin
            modelScreen[i] = 8'h20;
        end
        modelRow = 0;
        modelCol = 0;
    endtask

    // parser rules applied to the reference screen
    task automatic applyByte(input logic [7:0] value);
        case (modelState)
            ModelGround: begin
                if (value >= 8'h20 && value <= 8'h7E) begin
                    modelScreen[modelRow * Columns + modelCol] = value;
                    if (modelCol == Columns - 1) begin
                        modelCol = 0;
                        modelRow = (modelRow + 1) % Rows;
                    end else begin
                        modelCol = modelCol + 1;
                    end
                end else if (value == 8'h0D) begin
                    modelCol = 0;
                end else if (value == 8'h0A) begin
                    modelRow = (modelRow + 1) % Rows;
                end else if (value == 8'h08) begin
                    if (modelCol > 0) begin
                        modelCol = modelCol - 1;
                    end
                end else if (value == 8'h1B) begin
                    modelState = ModelEscape;
                end
            end
            ModelEscape: begin
                modelState = (value == 8'h5B) ? ModelCsi : ModelGround;
            end
            ModelCsi: begin
                modelState = ModelGround;
                if (value == 8'h48) begin
                    modelRow = 0;
                    modelCol = 0;
                end else if (value == 8'h32) begin
                    modelState = ModelCsiTwo;
                end
            end
            ModelCsiTwo: begin
                modelState = ModelGround;
                if (value == 8'h4A) begin
                    clearModel();
                end
            end
            default: modelState = ModelGround;
        endcase
    endtask

    // one 8N1 frame, lsb first, then a short idle gap
    task automatic sendByte(input logic [7:0] value);
        logic [9:0] frame;
        frame = {1'b1, value, 1'b0};
        for (int i = 0; i < 10; i++) begin
            @(posedge clk);
            uartRx <= frame[i];
            repeat (ClksPerBit - 1) @(posedge clk);
        end
        repeat (4) @(posedge clk);
        applyByte(value);
    endtask

    task automatic readCell(input int row, input int col, input int line,
                            output logic [7:0] bits);
        @(posedge clk);
        readRow  <= row[2:0];
        readCol  <= col[3:0];
        readLine <= line[2:0];
        readReq  <= 1'b1;
        @(negedge clk);
        while (!readAck) @(negedge clk);
        bits = glyphBits;
        @(posedge clk);
        readReq <= 1'b0;
        @(negedge clk);
        while (readAck) @(negedge clk);
    endtask

    // line L of code C is C rotated left by L, inverted on the cursor
    function automatic logic [7:0] expectedGlyph(input int row, input int col, input int line);
        logic [15:0] doubled;
        logic [7:0]  code;
        logic [7:0]  result;
        code    = modelScreen[row * Columns + col];
        doubled = {code, code} << line;
        result  = doubled[15:8];
        if (row == modelRow && col == modelCol) begin
            result = ~result;
        end
        return result;
    endfunction

    task automatic checkCell(input string testName, input int row, input int col);
        logic [31:0] draw;
        int          line;
        logic [7:0]  expected;
        logic [7:0]  actual;
        nextRandom(draw);
        line     = int'(draw[2:0]);
        expected = expectedGlyph(row, col, line);
        readCell(row, col, line, actual);
        assert (actual == expected) else begin
            $display("[FAIL] %s: cell (%0d,%0d) line %0d expected %02h actual %02h",
                     testName, row, col, line, expected, actual);
            stopOnError();
        end
    endtask

    task automatic checkScreen(input string testName);
        for (int row = 0; row < Rows; row++) begin
            for (int col = 0; col < Columns; col++) begin
                checkCell(testName, row, col);
            end
        end
    endtask

    initial begin
        logic [31:0] draw;
        logic [7:0]  character;
        int          writtenRow;
        int          writtenCol;
        reset      = 1'b1;
        uartRx     = 1'b1;
        readReq    = 1'b0;
        readRow    = '0;
        readCol    = '0;
        readLine   = '0;
        rngState   = 32'd70747;
        cycleCount = 0;
        prevReq    = 1'b0;
        prevAck    = 1'b0;
        prevGlyph  = '0;
        modelState = ModelGround;
        clearModel();

        repeat (5) @(posedge clk);
        reset <= 1'b0;
        // reset starts the clear sweep
        repeat (140) @(posedge clk);
        checkScreen("after reset");

        // random text that wraps past row ends
        for (int i = 0; i < 40; i++) begin
            nextRandom(draw);
            character  = 8'h20 + 8'(draw % 32'd95);
            writtenRow = modelRow;
            writtenCol = modelCol;
            sendByte(character);
            checkCell("random text", writtenRow, writtenCol);
            checkCell("random text cursor", modelRow, modelCol);
        end
        checkScreen("random text screen");

        sendByte(8'h0D);
        checkCell("carriage return", modelRow, modelCol);
        sendByte(8'h08);
        checkCell("backspace at column 0", modelRow, modelCol);
        sendByte(8'h41);
        sendByte(8'h42);
        sendByte(8'h08);
        checkCell("backspace", modelRow, modelCol);
        while (modelRow != Rows - 1) begin
            sendByte(8'h0A);
            checkCell("line feed", modelRow, modelCol);
        end
        sendByte(8'h0A);
        checkCell("line feed wrap", modelRow, modelCol);

        // bell, delete, high byte and dropped escape sequences
        sendByte(8'h07);
        sendByte(8'h7F);
        sendByte(8'h80);
        sendByte(8'h1B);
        sendByte(8'h58);
        sendByte(8'h1B);
        sendByte(8'h5B);
        sendByte(8'h4B);
        sendByte(8'h1B);
        sendByte(8'h5B);
        sendByte(8'h32);
        sendByte(8'h4B);
        checkScreen("unsupported bytes");

        // cursor off row 0 and column 0 before homing
        sendByte(8'h0A);
        sendByte(8'h1B);
        sendByte(8'h5B);
        sendByte(8'h48);
        checkScreen("cursor home");

        // cursor away from home and one more cell written
        sendByte(8'h0A);
        sendByte(8'h5A);
        sendByte(8'h1B);
        sendByte(8'h5B);
        sendByte(8'h32);
        sendByte(8'h4A);
        // 128-cell sweep plus margin
        repeat (140) @(posedge clk);
        checkScreen("clear screen");

        $display("Verification passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== textRam.sv ====
`timescale 1ns/1ps
`default_nettype none

module textRam
    import consolePkg::*;
#(
    parameter int Rows    = 8,
    parameter int Columns = 16
) (
    input  wire          clk,
    input  wire          writeEnable,
    input  wire          [6:0] writeAddress,
    input  wire          [7:0] writeData,
    input  wire          [6:0] readAddress,
    output CharCode_t    readData
);

    localparam int Depth = Rows * Columns;

    // one byte per character cell
    CharCode_t memory [Depth];

    // port A, parser side
    always_ff @(posedge clk) begin
        if (writeEnable) begin
            memory[writeAddress] <= writeData;
        end
    end

    // port B, renderer side, one cycle latency
    always_ff @(posedge clk) begin
        readData <= memory[readAddress];
    end

endmodule

`default_nettype wire

// ==== uartPkg.sv ====
`default_nettype none

package uartPkg;

    // one received data byte
    typedef logic [7:0] UartByte_t;

    // data bits seen so far in a frame
    typedef logic [3:0] BitCount_t;

    // clocks counted inside one bit
    typedef logic [15:0] SampleCount_t;

    typedef enum logic [1:0] {
        idle,
        start,
        data,
        stop
    } RxState_t;

endpackage

`default_nettype wire

// ==== uartReceiver.sv ====
`timescale 1ns/1ps
`default_nettype none

module uartReceiver
    import uartPkg::*;
#(
    parameter int ClksPerBit = 16
) (
    input  wire       clk,
    input  wire       reset,
    input  wire       uartRx,
    output UartByte_t rxData,
    output logic      rxValid
);

    localparam SampleCount_t LastSample = SampleCount_t'(ClksPerBit - 1);
    localparam SampleCount_t HalfSample = SampleCount_t'(ClksPerBit / 2 - 1);

    logic         rxMeta;
    logic         rxSync;
    RxState_t     state;
    SampleCount_t sampleCount;
    BitCount_t    bitCount;
    UartByte_t    shiftReg;
    logic         bitEnd;

    // line idles high
    always_ff @(posedge clk) begin
        if (reset) begin
            rxMeta <= 1'b1;
            rxSync <= 1'b1;
        end else begin
            rxMeta <= uartRx;
            rxSync <= rxMeta;
        end
    end

    assign bitEnd = (sampleCount == LastSample);

    always_ff @(posedge clk) begin
        if (reset) begin
            state       <= idle;
            sampleCount <= '0;
            bitCount    <= '0;
            rxValid     <= 1'b0;
        end else begin
            rxValid <= 1'b0;
            case (state)
                idle: begin
                    sampleCount <= '0;
                    if (!rxSync) begin
                        state <= start;
                    end
                end
                start: begin
                    if (sampleCount == HalfSample) begin
                        sampleCount <= '0;
                        bitCount    <= '0;
                        // a glitch shorter than half a bit is ignored
                        state       <= rxSync ? idle : data;
                    end else begin
                        sampleCount <= sampleCount + 1'b1;
                    end
                end
                data: begin
                    if (bitEnd) begin
                        sampleCount <= '0;
                        bitCount    <= bitCount + 1'b1;
                        if (bitCount == BitCount_t'(7)) begin
                            state <= stop;
                        end
                    end else begin
                        sampleCount <= sampleCount + 1'b1;
                    end
                end
                stop: begin
                    if (bitEnd) begin
                        // low stop bit means a framing error, drop the byte
                        rxValid <= rxSync;
                        state   <= idle;
                    end else begin
                        sampleCount <= sampleCount + 1'b1;
                    end
                end
                default: state <= idle;
            endcase
        end
    end

    // lsb arrives first
    always_ff @(posedge clk) begin
        if (state == data && bitEnd) begin
            shiftReg <= {rxSync, shiftReg[7:1]};
        end
        if (state == stop && bitEnd) begin
            rxData <= shiftReg;
        end
    end

endmodule

`default_nettype wire

// ==== virtualConsole.f ====
consolePkg.sv
uartPkg.sv
uartReceiver.sv
vt100Parser.sv
textRam.sv
fontRom.sv
glyphRenderer.sv
virtualConsole.sv
tbVirtualConsole.sv

// ==== virtualConsole.sv ====
`timescale 1ns/1ps
`default_nettype none

module virtualConsole
    import consolePkg::*;
    import uartPkg::*;
#(
    parameter int ClksPerBit = 16,
    parameter int Rows       = 8,
    parameter int Columns    = 16
) (
    input  wire        clk,
    input  wire        reset,
    input  wire        uartRx,
    input  wire        readReq,
    input  wire        [2:0] readRow,
    input  wire        [3:0] readCol,
    input  wire        [2:0] readLine,
    output logic       readAck,
    output GlyphLine_t glyphBits
);

    // serial link
    UartByte_t    rxData;
    logic         rxValid;

    // parser write port and cursor
    logic         writeEnable;
    CellAddress_t writeAddress;
    CharCode_t    writeData;
    RowIndex_t    cursorRow;
    ColIndex_t    cursorCol;

    // renderer fetch path
    CellAddress_t readAddress;
    CharCode_t    readData;
    CharCode_t    fontCode;
    LineIndex_t   fontLine;
    GlyphLine_t   fontBits;

    uartReceiver #(
        .ClksPerBit(ClksPerBit)
    ) receiver (
        .clk(clk),
        .reset(reset),
        .uartRx(uartRx),
        .rxData(rxData),
        .rxValid(rxValid)
    );

    vt100Parser #(
        .Rows(Rows),
        .Columns(Columns)
    ) parser (
        .clk(clk),
        .reset(reset),
        .rxValid(rxValid),
        .rxData(rxData),
        .writeEnable(writeEnable),
        .writeAddress(writeAddress),
        .writeData(writeData),
        .cursorRow(cursorRow),
        .cursorCol(cursorCol)
    );

    textRam #(
        .Rows(Rows),
        .Columns(Columns)
    ) screenRam (
        .clk(clk),
        .writeEnable(writeEnable),
        .writeAddress(writeAddress),
        .writeData(writeData),
        .readAddress(readAddress),
        .readData(readData)
    );

    fontRom font (
        .clk(clk),
        .fontCode(fontCode),
        .fontLine(fontLine),
        .fontBits(fontBits)
    );

    glyphRenderer #(
        .Rows(Rows),
        .Columns(Columns)
    ) renderer (
        .clk(clk),
        .reset(reset),
        .readReq(readReq),
        .readRow(readRow),
        .readCol(readCol),
        .readLine(readLine),
        .readAck(readAck),
        .glyphBits(glyphBits),
        .cursorRow(cursorRow),
        .cursorCol(cursorCol),
        .readAddress(readAddress),
        .readData(readData),
        .fontCode(fontCode),
        .fontLine(fontLine),
        .fontBits(fontBits)
    );

endmodule

`default_nettype wire

// ==== vt100Parser.sv ====
`timescale 1ns/1ps
`default_nettype none

module vt100Parser
    import consolePkg::*;
    import uartPkg::*;
#(
    parameter int Rows    = 8,
    parameter int Columns = 16
) (
    input  wire          clk,
    input  wire          reset,
    input  wire          rxValid,
    input  wire          [7:0] rxData,
    output logic         writeEnable,
    output CellAddress_t writeAddress,
    output CharCode_t    writeData,
    output RowIndex_t    cursorRow,
    output ColIndex_t    cursorCol
);

    localparam RowIndex_t    LastRow = RowIndex_t'(Rows - 1);
    localparam ColIndex_t    LastCol = ColIndex_t'(Columns - 1);
    localparam CellAddress_t LastCell = CellAddress_t'(Rows * Columns - 1);

    // control bytes and sequence characters
    localparam UartByte_t CharBackspace = 8'h08;
    localparam UartByte_t CharLineFeed  = 8'h0A;
    localparam UartByte_t CharReturn    = 8'h0D;
    localparam UartByte_t CharEscape    = 8'h1B;
    localparam UartByte_t CharBracket   = 8'h5B;
    localparam UartByte_t CharTwo       = 8'h32;
    localparam UartByte_t CharHome      = 8'h48;
    localparam UartByte_t CharClear     = 8'h4A;
    localparam CharCode_t Space         = 8'h20;

    ParserState_t state;
    CellAddress_t clearAddress;
    RowIndex_t    nextRow;
    logic         printable;

    // no scrolling, the last row wraps to row 0
    assign nextRow   = (cursorRow == LastRow) ? '0 : cursorRow + 1'b1;
    assign printable = (rxData >= 8'h20) && (rxData <= 8'h7E);

    always_ff @(posedge clk) begin
        if (reset) begin
            // reset starts the same sweep as ESC [ 2 J
            state        <= clearing;
            clearAddress <= '0;
            cursorRow    <= '0;
            cursorCol    <= '0;
            writeEnable  <= 1'b0;
        end else begin
            writeEnable <= 1'b0;
            case (state)
                ground: begin
                    if (rxValid && printable) begin
                        writeEnable <= 1'b1;
                        if (cursorCol == LastCol) begin
                            cursorCol <= '0;
                            cursorRow <= nextRow;
                        end else begin
                            cursorCol <= cursorCol + 1'b1;
                        end
                    end else if (rxValid) begin
                        case (rxData)
                            CharReturn:    cursorCol <= '0;
                            CharLineFeed:  cursorRow <= nextRow;
                            CharBackspace: begin
                                if (cursorCol != '0) begin
                                    cursorCol <= cursorCol - 1'b1;
                                end
                            end
                            CharEscape:    state <= escape;
                            default:       ;
                        endcase
                    end
                end
                escape: begin
                    if (rxValid) begin
                        state <= (rxData == CharBracket) ? csi : ground;
                    end
                end
                csi: begin
                    if (rxValid) begin
                        state <= ground;
                        if (rxData == CharHome) begin
                            cursorRow <= '0;
                            cursorCol <= '0;
                        end else if (rxData == CharTwo) begin
                            state <= csiTwo;
                        end
                    end
                end
                csiTwo: begin
                    if (rxValid) begin
                        state        <= (rxData == CharClear) ? clearing : ground;
                        clearAddress <= '0;
                    end
                end
                clearing: begin
                    // one cell per cycle, incoming bytes are lost
                    writeEnable  <= 1'b1;
                    clearAddress <= clearAddress + 1'b1;
                    if (clearAddress == LastCell) begin
                        state     <= ground;
                        cursorRow <= '0;
                        cursorCol <= '0;
                    end
                end
                default: state <= ground;
            endcase
        end
    end

    // address and data follow writeEnable by the same register stage
    always_ff @(posedge clk) begin
        if (state == clearing) begin
            writeAddress <= clearAddress;
            writeData    <= Space;
        end else begin
            writeAddress <= cellAddress(cursorRow, cursorCol, Rows, Columns);
            writeData    <= rxData;
        end
    end

endmodule

`default_nettype wire
